/* src/fifo_pkg.sv */
`default_nettype none

package fifo_pkg;

  localparam int data_width = 8;
  localparam int fifo_depth = 16;
  localparam int addr_width = $clog2(fifo_depth);
  // extra msb marks the wrap, so full and empty differ
  localparam int ptr_width  = addr_width + 1;

  localparam int fifo_afull  = 15; // used words at or above this
  localparam int fifo_aempty = 1;  // used words at or below this

  function automatic logic [ptr_width-1:0] bin2gray(input logic [ptr_width-1:0] bin);
    return bin ^ (bin >> 1);
  endfunction

  // msb passes through, each lower bit folds in the bits above it
  function automatic logic [ptr_width-1:0] gray2bin(input logic [ptr_width-1:0] gray);
    logic [ptr_width-1:0] bin;
    bin[ptr_width-1] = gray[ptr_width-1];
    for (int i = ptr_width - 2; i >= 0; i--) begin
      bin[i] = bin[i+1] ^ gray[i];
    end
    return bin;
  endfunction

endpackage

`default_nettype wire

/* src/dualport_ram.sv */
`timescale 1ns/10ps
`default_nettype none

module dualport_ram (
  input  logic                            wr_clk,
  input  logic                            wr_accept,
  input  logic [fifo_pkg::addr_width-1:0] wr_addr,
  input  logic [fifo_pkg::data_width-1:0] wr_data,
  input  logic                            rd_clk,
  input  logic                            rd_rst_n,
  input  logic                            rd_accept,
  input  logic [fifo_pkg::addr_width-1:0] rd_addr,
  output logic [fifo_pkg::data_width-1:0] rd_data
);

  logic [fifo_pkg::data_width-1:0] mem [fifo_pkg::fifo_depth];

  // write port
  always_ff @(posedge wr_clk) begin
    if (wr_accept) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // read port, holds the last word until the next accepted read
  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      rd_data <= '0;
    end else if (rd_accept) begin
      rd_data <= mem[rd_addr];
    end
  end

endmodule

`default_nettype wire

/* src/wr_ptr_ctrl.sv */
`timescale 1ns/10ps
`default_nettype none

module wr_ptr_ctrl (
  input  logic                            wr_clk,
  input  logic                            wr_rst_n,
  input  logic                            wr_en,
  input  logic [fifo_pkg::ptr_width-1:0]  rd_ptr_gray,
  output logic                            wr_accept,
  output logic [fifo_pkg::addr_width-1:0] wr_addr,
  output logic [fifo_pkg::ptr_width-1:0]  wr_ptr_gray,
  output logic                            full,
  output logic                            afull
);

  logic [fifo_pkg::ptr_width-1:0] wr_ptr;
  logic [fifo_pkg::ptr_width-1:0] wr_ptr_nxt;
  logic [fifo_pkg::ptr_width-1:0] wr_gray_nxt;

  logic [fifo_pkg::ptr_width-1:0] rd_gray_sync1;
  logic [fifo_pkg::ptr_width-1:0] rd_gray_sync2;
  logic [fifo_pkg::ptr_width-1:0] rd_ptr_bin;
  logic [fifo_pkg::ptr_width-1:0] full_match;

  logic [fifo_pkg::ptr_width-1:0] used_nxt;
  logic                           full_nxt;
  logic                           afull_nxt;

  assign wr_accept = wr_en & ~full; // writes while full are dropped

  always_comb begin
    if (wr_accept) begin
      wr_ptr_nxt = wr_ptr + 1'b1;
    end else begin
      wr_ptr_nxt = wr_ptr;
    end
  end

  assign wr_gray_nxt = fifo_pkg::bin2gray(wr_ptr_nxt);
  assign wr_addr     = wr_ptr[fifo_pkg::addr_width-1:0];

  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      wr_ptr      <= '0;
      wr_ptr_gray <= '0;
    end else begin
      wr_ptr      <= wr_ptr_nxt;
      wr_ptr_gray <= wr_gray_nxt; // gray copy changes on the accepting edge
    end
  end

  // read pointer into the write domain
  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      rd_gray_sync1 <= '0;
      rd_gray_sync2 <= '0;
    end else begin
      rd_gray_sync1 <= rd_ptr_gray;
      rd_gray_sync2 <= rd_gray_sync1;
    end
  end

  // full when the write pointer is one lap ahead of the read pointer,
  // which in gray code flips the two top bits
  assign full_match = {~rd_gray_sync2[fifo_pkg::ptr_width-1:fifo_pkg::ptr_width-2],
                       rd_gray_sync2[fifo_pkg::ptr_width-3:0]};
  assign full_nxt   = (wr_gray_nxt == full_match);

  assign rd_ptr_bin = fifo_pkg::gray2bin(rd_gray_sync2);
  assign used_nxt   = wr_ptr_nxt - rd_ptr_bin; // stale read side, so never low
  assign afull_nxt  = (used_nxt >= fifo_pkg::ptr_width'(fifo_pkg::fifo_afull));

  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      full  <= 1'b0;
      afull <= 1'b0;
    end else begin
      full  <= full_nxt;
      afull <= afull_nxt;
    end
  end

endmodule

`default_nettype wire

/* src/rd_ptr_ctrl.sv */
`timescale 1ns/10ps
`default_nettype none

module rd_ptr_ctrl (
  input  logic                            rd_clk,
  input  logic                            rd_rst_n,
  input  logic                            rd_en,
  input  logic [fifo_pkg::ptr_width-1:0]  wr_ptr_gray,
  output logic                            rd_accept,
  output logic [fifo_pkg::addr_width-1:0] rd_addr,
  output logic [fifo_pkg::ptr_width-1:0]  rd_ptr_gray,
  output logic                            empty,
  output logic                            aempty
);

  logic [fifo_pkg::ptr_width-1:0] rd_ptr;
  logic [fifo_pkg::ptr_width-1:0] rd_ptr_nxt;
  logic [fifo_pkg::ptr_width-1:0] rd_gray_nxt;

  logic [fifo_pkg::ptr_width-1:0] wr_gray_sync1;
  logic [fifo_pkg::ptr_width-1:0] wr_gray_sync2;
  logic [fifo_pkg::ptr_width-1:0] wr_ptr_bin;

  logic [fifo_pkg::ptr_width-1:0] used_nxt;
  logic                           empty_nxt;
  logic                           aempty_nxt;

  assign rd_accept = rd_en & ~empty; // reads while empty are dropped

  always_comb begin
    if (rd_accept) begin
      rd_ptr_nxt = rd_ptr + 1'b1;
    end else begin
      rd_ptr_nxt = rd_ptr;
    end
  end

  assign rd_gray_nxt = fifo_pkg::bin2gray(rd_ptr_nxt);

  // the ram registers the word, so the current pointer addresses it
  assign rd_addr = rd_ptr[fifo_pkg::addr_width-1:0];

  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      rd_ptr      <= '0;
      rd_ptr_gray <= '0;
    end else begin
      rd_ptr      <= rd_ptr_nxt;
      rd_ptr_gray <= rd_gray_nxt;
    end
  end

  // write pointer into the read domain
  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      wr_gray_sync1 <= '0;
      wr_gray_sync2 <= '0;
    end else begin
      wr_gray_sync1 <= wr_ptr_gray;
      wr_gray_sync2 <= wr_gray_sync1;
    end
  end

  assign empty_nxt = (rd_gray_nxt == wr_gray_sync2);

  // write side is seen late, so the count can only be under the truth
  assign wr_ptr_bin = fifo_pkg::gray2bin(wr_gray_sync2);
  assign used_nxt   = wr_ptr_bin - rd_ptr_nxt;
  assign aempty_nxt = (used_nxt <= fifo_pkg::ptr_width'(fifo_pkg::fifo_aempty));

  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      empty  <= 1'b1; // nothing stored out of reset
      aempty <= 1'b1;
    end else begin
      empty  <= empty_nxt;
      aempty <= aempty_nxt;
    end
  end

endmodule

`default_nettype wire

/* src/async_fifo.sv */
`timescale 1ns/10ps
`default_nettype none

module async_fifo (
  input  logic                            wr_clk,
  input  logic                            wr_rst_n,
  input  logic                            wr_en,
  input  logic [fifo_pkg::data_width-1:0] wr_data,
  input  logic                            rd_clk,
  input  logic                            rd_rst_n,
  input  logic                            rd_en,
  output logic [fifo_pkg::data_width-1:0] rd_data,
  output logic                            full,
  output logic                            afull,
  output logic                            empty,
  output logic                            aempty
);

  // write domain
  logic                            wr_accept;
  logic [fifo_pkg::addr_width-1:0] wr_addr;
  logic [fifo_pkg::ptr_width-1:0]  wr_ptr_gray; // crosses to rd_clk

  // read domain
  logic                            rd_accept;
  logic [fifo_pkg::addr_width-1:0] rd_addr;
  logic [fifo_pkg::ptr_width-1:0]  rd_ptr_gray; // crosses to wr_clk

  wr_ptr_ctrl u_wr_ptr_ctrl (
    .wr_clk      (wr_clk),
    .wr_rst_n    (wr_rst_n),
    .wr_en       (wr_en),
    .rd_ptr_gray (rd_ptr_gray),
    .wr_accept   (wr_accept),
    .wr_addr     (wr_addr),
    .wr_ptr_gray (wr_ptr_gray),
    .full        (full),
    .afull       (afull)
  );

  rd_ptr_ctrl u_rd_ptr_ctrl (
    .rd_clk      (rd_clk),
    .rd_rst_n    (rd_rst_n),
    .rd_en       (rd_en),
    .wr_ptr_gray (wr_ptr_gray),
    .rd_accept   (rd_accept),
    .rd_addr     (rd_addr),
    .rd_ptr_gray (rd_ptr_gray),
    .empty       (empty),
    .aempty      (aempty)
  );

  dualport_ram u_dualport_ram (
    .wr_clk    (wr_clk),
    .wr_accept (wr_accept),
    .wr_addr   (wr_addr),
    .wr_data   (wr_data),
    .rd_clk    (rd_clk),
    .rd_rst_n  (rd_rst_n),
    .rd_accept (rd_accept),
    .rd_addr   (rd_addr),
    .rd_data   (rd_data)
  );

endmodule

`default_nettype wire

/* verif/async_fifo_asserts.sv */
`timescale 1ns/10ps
`default_nettype none

module async_fifo_asserts (
  input logic                            wr_clk,
  input logic                            wr_rst_n,
  input logic                            rd_clk,
  input logic                            rd_rst_n,
  input logic                            rd_accept,
  input logic [fifo_pkg::data_width-1:0] rd_data,
  input logic                            full,
  input logic                            afull,
  input logic                            empty,
  input logic                            aempty
);

  int fail_count = 0; // read by the testbench at the end

  // write side flags are clear while held in reset
  wr_reset_flags: assert property (@(posedge wr_clk) !wr_rst_n |-> (!full && !afull))
    else begin
      $error("full or afull set during write reset");
      fail_count++;
    end

  // read side starts out empty
  rd_reset_flags: assert property (@(posedge rd_clk) !rd_rst_n |-> (empty && aempty))
    else begin
      $error("empty or aempty clear during read reset");
      fail_count++;
    end

  full_implies_afull: assert property (@(posedge wr_clk) disable iff (!wr_rst_n)
                                        full |-> afull)
    else begin
      $error("full set without afull");
      fail_count++;
    end

  empty_implies_aempty: assert property (@(posedge rd_clk) disable iff (!rd_rst_n)
                                          empty |-> aempty)
    else begin
      $error("empty set without aempty");
      fail_count++;
    end

  rd_data_hold: assert property (@(posedge rd_clk) disable iff (!rd_rst_n)
                                  !rd_accept |=> $stable(rd_data))
    else begin
      $error("rd_data changed with no accepted read");
      fail_count++;
    end

endmodule

`default_nettype wire

/* verif/async_fifo_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module async_fifo_tb;

  localparam int reset_cycles   = 16;
  localparam int idle_cycles    = 10;
  localparam int traffic_cycles = 2000;
  localparam int wait_limit     = 4 * fifo_pkg::fifo_depth + 20;

  logic                            wr_clk;
  logic                            wr_rst_n;
  logic                            wr_en;
  logic [fifo_pkg::data_width-1:0] wr_data;
  logic                            rd_clk;
  logic                            rd_rst_n;
  logic                            rd_en;
  logic [fifo_pkg::data_width-1:0] rd_data;
  logic                            full;
  logic                            afull;
  logic                            empty;
  logic                            aempty;

  logic [fifo_pkg::data_width-1:0] ref_q [$];
  logic [fifo_pkg::data_width-1:0] exp_word;
  logic                            check_due = 1'b0;
  logic                            traffic_done;
  logic [15:0]                     lfsr_state;

  int errors       = 0;
  int tests_run    = 0;
  int tests_failed = 0;
  int wr_accepted  = 0;
  int rd_accepted  = 0;
  int test_start   = 0;

  async_fifo UUT (
    .wr_clk   (wr_clk),
    .wr_rst_n (wr_rst_n),
    .wr_en    (wr_en),
    .wr_data  (wr_data),
    .rd_clk   (rd_clk),
    .rd_rst_n (rd_rst_n),
    .rd_en    (rd_en),
    .rd_data  (rd_data),
    .full     (full),
    .afull    (afull),
    .empty    (empty),
    .aempty   (aempty)
  );

  bind async_fifo async_fifo_asserts u_asserts (
    .wr_clk    (wr_clk),
    .wr_rst_n  (wr_rst_n),
    .rd_clk    (rd_clk),
    .rd_rst_n  (rd_rst_n),
    .rd_accept (rd_accept),
    .rd_data   (rd_data),
    .full      (full),
    .afull     (afull),
    .empty     (empty),
    .aempty    (aempty)
  );

  // rising edges at 5+10k and 3.5+7k never coincide
  initial begin
    rd_clk = 1'b0;
    forever #5 rd_clk = ~rd_clk;
  end

  initial begin
    wr_clk = 1'b0;
    forever #3.5 wr_clk = ~wr_clk;
  end

  function automatic logic lfsr_bit();
    logic lsb;
    lsb = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (lsb) begin
      lfsr_state = lfsr_state ^ 16'hb400; // x^16+x^14+x^13+x^11+1
    end
    return lsb;
  endfunction

  function automatic logic [fifo_pkg::data_width-1:0] lfsr_byte();
    logic [fifo_pkg::data_width-1:0] b;
    b = '0;
    for (int i = 0; i < fifo_pkg::data_width; i++) begin
      b = {b[fifo_pkg::data_width-2:0], lfsr_bit()};
    end
    return b;
  endfunction

  function automatic int total_errors();
    return errors + UUT.u_asserts.fail_count;
  endfunction

  task automatic check_flag(input string name, input logic got, input logic exp);
    assert (got === exp) else begin
      $display("** Error: %s = %h, expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
    assert (got === exp) else begin
      $display("** Error: %s = %h, expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_count(input string what, input int got, input int exp);
    assert (got == exp) else begin
      $display("%s was %0d but should be %0d", what, got, exp);
      errors++;
    end
  endtask

  task automatic end_test(input string name);
    int errs;
    errs = total_errors() - test_start;
    tests_run++;
    if (errs == 0) begin
      $display("test %0d %s: pass", tests_run, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: FAIL with %0d errors", tests_run, name, errs);
    end
    test_start = total_errors();
  endtask

  // accepted writes, judged like the DUT does at the edge
  always @(posedge wr_clk) begin
    if (wr_rst_n && wr_en && !full) begin
      ref_q.push_back(wr_data);
      wr_accepted++;
    end
  end

  // registered read port, so the word is due one edge after the accept
  always @(posedge rd_clk) begin
    if (check_due) begin
      check_byte("rd_data", rd_data, exp_word);
      check_due = 1'b0;
    end
    if (rd_rst_n && rd_en && !empty) begin
      rd_accepted++;
      if (ref_q.size() == 0) begin
        $display("a read was accepted while the reference queue was empty");
        errors++;
      end else begin
        exp_word  = ref_q.pop_front();
        check_due = 1'b1;
      end
    end
  end

  task automatic idle_both();
    repeat (idle_cycles) @(posedge wr_clk);
    repeat (idle_cycles) @(posedge rd_clk);
    @(negedge rd_clk);
  endtask

  task automatic write_words(input int n);
    for (int i = 0; i < n; i++) begin
      @(posedge wr_clk);
      wr_en   <= 1'b1;
      wr_data <= lfsr_byte();
    end
    @(posedge wr_clk);
    wr_en <= 1'b0;
  endtask

  // leaves wr_en high on return
  task automatic fill_until_full(output int writes);
    int start;
    int n;
    start = wr_accepted;
    n = 0;
    @(negedge wr_clk);
    while (!full && n < wait_limit) begin
      @(posedge wr_clk);
      wr_en   <= 1'b1;
      wr_data <= lfsr_byte();
      @(negedge wr_clk);
      n++;
    end
    if (!full) begin
      $display("timed out waiting for full while writing");
      errors++;
    end
    writes = wr_accepted - start;
  endtask

  task automatic drain_until_empty(output int reads);
    int start;
    int n;
    start = rd_accepted;
    n = 0;
    @(negedge rd_clk);
    while (!empty && n < wait_limit) begin
      @(posedge rd_clk);
      rd_en <= 1'b1;
      @(negedge rd_clk);
      n++;
    end
    if (!empty) begin
      $display("timed out waiting for empty while reading");
      errors++;
    end
    @(posedge rd_clk);
    rd_en <= 1'b0;
    @(negedge rd_clk); // last data check has run by now
    reads = rd_accepted - start;
  endtask

  // flags against the package thresholds, with the queue as occupancy
  task automatic check_levels(input int stored);
    int used;
    used = ref_q.size();
    check_count("stored words", used, stored);
    check_flag("full", full, used >= fifo_pkg::fifo_depth);
    check_flag("afull", afull, used >= fifo_pkg::fifo_afull);
    check_flag("empty", empty, used == 0);
    check_flag("aempty", aempty, used <= fifo_pkg::fifo_aempty);
  endtask

  initial begin
    int n;
    logic [fifo_pkg::data_width-1:0] held;
    lfsr_state   = 16'd28090;
    traffic_done = 1'b0;
    wr_rst_n     = 1'b1;
    rd_rst_n     = 1'b1;
    wr_en        = 1'b0;
    rd_en        = 1'b0;
    wr_data      = '0;
    #1;
    // falling edge resets every flop before the first clock edge
    wr_rst_n = 1'b0;
    rd_rst_n = 1'b0;
    repeat (reset_cycles) @(posedge rd_clk);
    rd_rst_n <= 1'b1;
    @(posedge wr_clk);
    wr_rst_n <= 1'b1;
    @(negedge rd_clk);
    test_start = total_errors();

    check_flag("empty", empty, 1'b1);
    check_flag("aempty", aempty, 1'b1);
    check_flag("full", full, 1'b0);
    check_flag("afull", afull, 1'b0);
    check_byte("rd_data", rd_data, 8'h00);
    end_test("reset state");

    fill_until_full(n);
    check_count("writes accepted up to full", n, fifo_pkg::fifo_depth);
    check_flag("afull", afull, 1'b1);
    n = wr_accepted;
    repeat (4) begin
      @(posedge wr_clk);
      wr_data <= lfsr_byte(); // wr_en still high, all dropped
    end
    @(posedge wr_clk);
    wr_en <= 1'b0;
    @(negedge wr_clk);
    check_count("writes accepted while full", wr_accepted - n, 0);
    end_test("fill and full");

    drain_until_empty(n);
    check_count("words read back", n, fifo_pkg::fifo_depth);
    check_flag("empty", empty, 1'b1);
    check_count("words left in the reference queue", ref_q.size(), 0);
    held = rd_data;
    repeat (3) begin
      @(posedge rd_clk);
      rd_en <= 1'b1;
    end
    @(posedge rd_clk);
    rd_en <= 1'b0;
    @(negedge rd_clk);
    check_byte("rd_data", rd_data, held);
    end_test("drain order and empty");

    idle_both();
    write_words(1);
    idle_both();
    check_levels(1);
    write_words(1);
    idle_both();
    check_levels(2);
    write_words(12);
    idle_both();
    check_levels(14);
    write_words(1);
    idle_both();
    check_levels(15);
    drain_until_empty(n);
    end_test("thresholds");

    idle_both();
    fork
      begin
        repeat (traffic_cycles) begin
          @(posedge rd_clk);
          rd_en <= lfsr_bit();
        end
        @(posedge rd_clk);
        rd_en <= 1'b0;
        traffic_done = 1'b1;
      end
      begin
        n = 0;
        while (!traffic_done && n < 2 * traffic_cycles) begin
          @(posedge wr_clk);
          wr_en   <= lfsr_bit();
          wr_data <= lfsr_byte();
          n++;
        end
        @(posedge wr_clk);
        wr_en <= 1'b0;
      end
    join
    idle_both();
    drain_until_empty(n);
    check_count("words left in the reference queue", ref_q.size(), 0);
    check_count("total reads against total writes", rd_accepted, wr_accepted);
    end_test("random traffic");

    $display("tests run %0d, passed %0d, failed %0d, checker errors %0d, assertion failures %0d",
             tests_run, tests_run - tests_failed, tests_failed, errors,
             UUT.u_asserts.fail_count);
    if (tests_failed == 0 && total_errors() == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* async_fifo.f */
src/fifo_pkg.sv
src/dualport_ram.sv
src/wr_ptr_ctrl.sv
src/rd_ptr_ctrl.sv
src/async_fifo.sv
verif/async_fifo_asserts.sv
verif/async_fifo_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --timing --assert --timescale 1ns/10ps
TOP       = async_fifo_tb
FILELIST  = async_fifo.f
OBJDIR    = obj_dir
PASS_MSG  = Everything OK

.PHONY: all lint sim clean

all: sim

# static checks over the whole project, testbench included
lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

# build and run; the run passes only if the pass line shows up in the output
sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)
